/* chip_io_pkg.sv */
package chip_io_pkg;

	// Mode pins as presented on the two mode select pads
	typedef enum logic [1:0] {
		mode_reset   = 2'd0,
		mode_debug   = 2'd1,
		mode_run     = 2'd2,
		mode_memload = 2'd3
	} mode_e;

	// Ports A and B and the core output bus
	localparam int port_width = 8;

	// Pattern buffer serial address
	localparam int saddr_width = 3;

	// Instruction memory write side
	localparam int imem_adr_width = 10;
	localparam int pattern_width = 23;
	localparam int pattern_shift_width = 24;
	localparam int imem_word_width = 2 * pattern_width;

	// Byte shifter, filled by load_bytes strobes with the first byte on top
	localparam int load_word_width = 58;
	localparam int load_bytes = 8;

	// Field view of the shifter
	// Each pattern half is shifted in as 24 bits but stored as 23
	typedef struct packed {
		logic [imem_adr_width-1:0]                    adr;
		logic [pattern_shift_width-pattern_width-1:0] unused_hi;
		logic [pattern_width-1:0]                     pat_high;
		logic [pattern_shift_width-pattern_width-1:0] unused_lo;
		logic [pattern_width-1:0]                     pat_low;
	} imem_load_fields_t;

	// One shifter word, seen raw by the shifter and as fields by the decoder
	typedef union packed {
		logic [load_word_width-1:0] raw;
		imem_load_fields_t          field;
	} imem_load_word_u;

endpackage

/* input_sync.sv */
`timescale 1ns/10ps

module input_sync #(
	parameter int width = 12
) (
	input  logic             clk_int,
	input  logic             mode_is_reset,
	input  logic [width-1:0] async_in,
	output logic [width-1:0] sync_out
);

	// First stage may go metastable, only the second is read
	logic [width-1:0] meta_q;

	always_ff @(posedge clk_int or posedge mode_is_reset) begin
		if (mode_is_reset) begin
			meta_q   <= '0;
			sync_out <= '0;
		end else begin
			meta_q   <= async_in;
			sync_out <= meta_q;
		end
	end

endmodule

/* chip_control.sv */
`timescale 1ns/10ps

module chip_control #(
	parameter int clk_out_div_bits = 4
) (
	input  logic                clk_int,
	input  chip_io_pkg::mode_e  mode,
	// Port B bits 2 to 0, read as buffer resets in debug mode
	input  logic [2:0]          port_b_in,
	input  logic                division_pin,
	output logic                mode_is_reset,
	output logic                mode_is_debug,
	output logic                mode_is_run,
	output logic                mode_is_memload,
	output logic                reset_pat,
	output logic                reset_patternbuf_low,
	output logic                reset_patternbuf_high,
	output logic                pat_clock_division,
	output logic                clock_out
);

	logic                        debug_q;
	logic [clk_out_div_bits-1:0] clk_div;
	logic                        hold_reset;

	assign mode_is_reset   = (mode == chip_io_pkg::mode_reset);
	assign mode_is_debug   = (mode == chip_io_pkg::mode_debug);
	assign mode_is_run     = (mode == chip_io_pkg::mode_run);
	assign mode_is_memload = (mode == chip_io_pkg::mode_memload);

	// Core and buffers stay in reset while the memory is being loaded
	assign hold_reset = mode_is_reset | mode_is_memload;

	assign reset_pat             = hold_reset | (mode_is_debug & port_b_in[2]);
	assign reset_patternbuf_high = hold_reset | (mode_is_debug & port_b_in[1]);
	assign reset_patternbuf_low  = hold_reset | (mode_is_debug & port_b_in[0]);

	// Previous debug state, marks the first cycle after debug entry
	always_ff @(posedge clk_int or posedge mode_is_reset) begin
		if (mode_is_reset) begin
			debug_q <= 1'b0;
		end else begin
			debug_q <= mode_is_debug;
		end
	end

	// Slow pat clock by default, pin value taken once per debug entry
	always_ff @(posedge clk_int or posedge mode_is_reset) begin
		if (mode_is_reset) begin
			pat_clock_division <= 1'b1;
		end else if (mode_is_debug && !debug_q) begin
			pat_clock_division <= division_pin;
		end
	end

	// Free running divider, its top bit is the clock output pad
	always_ff @(posedge clk_int or posedge mode_is_reset) begin
		if (mode_is_reset) begin
			clk_div <= '0;
		end else begin
			clk_div <= clk_div + 1'b1;
		end
	end

	assign clock_out = clk_div[clk_out_div_bits-1];

	reset_pat_in_reset_mode: assert property (
		@(posedge clk_int) mode_is_reset |-> reset_pat
	) else $error("reset_pat low in reset mode");

endmodule

/* imem_loader.sv */
`timescale 1ns/10ps

module imem_loader (
	input  logic                                   clk_int,
	input  logic                                   mode_is_reset,
	input  logic                                   mode_is_memload,
	input  logic [chip_io_pkg::port_width-1:0]     port_a_sync,
	input  logic                                   load_strobe_sync,
	input  logic                                   load_write_sync,
	output logic [chip_io_pkg::imem_adr_width-1:0] imem_write_adr,
	output logic [chip_io_pkg::imem_word_width-1:0] imem_in,
	output logic                                   imem_write
);

	localparam int count_width = $clog2(chip_io_pkg::load_bytes + 1);
	localparam int keep_width = chip_io_pkg::load_word_width - chip_io_pkg::port_width;

	logic                        strobe_gated;
	logic                        strobe_prev;
	logic                        strobe_edge;
	chip_io_pkg::imem_load_word_u shifter;
	logic [count_width-1:0]      byte_count;

	// Strobe only counts in memory load mode
	assign strobe_gated = load_strobe_sync & mode_is_memload;
	assign strobe_edge  = strobe_gated & ~strobe_prev;

	always_ff @(posedge clk_int or posedge mode_is_reset) begin
		if (mode_is_reset) begin
			strobe_prev <= 1'b0;
		end else begin
			strobe_prev <= strobe_gated;
		end
	end

	// New byte enters at the bottom, older bytes move up
	always_ff @(posedge clk_int or posedge mode_is_reset) begin
		if (mode_is_reset) begin
			shifter.raw <= '0;
		end else if (strobe_edge) begin
			shifter.raw <= {shifter.raw[keep_width-1:0], port_a_sync};
		end
	end

	// Strobes seen in the current memory load session, saturating
	always_ff @(posedge clk_int or posedge mode_is_reset) begin
		if (mode_is_reset) begin
			byte_count <= '0;
		end else if (!mode_is_memload) begin
			byte_count <= '0;
		end else if (strobe_edge && byte_count != count_width'(chip_io_pkg::load_bytes)) begin
			byte_count <= byte_count + 1'b1;
		end
	end

	// Spare top bit of each 24-bit half is dropped here
	assign imem_write_adr = shifter.field.adr;
	assign imem_in        = {shifter.field.pat_high, shifter.field.pat_low};
	assign imem_write     = load_write_sync & mode_is_memload;

	write_only_in_memload: assert property (
		@(posedge clk_int) imem_write |-> mode_is_memload
	) else $error("imem_write outside memory load mode");

	write_after_full_word: assert property (
		@(posedge clk_int) disable iff (mode_is_reset)
		$rose(imem_write) |-> byte_count == count_width'(chip_io_pkg::load_bytes)
	) else $error("imem_write before a full word was shifted in");

endmodule

/* debug_port.sv */
`timescale 1ns/10ps

module debug_port (
	input  logic                                mode_is_debug,
	input  logic                                mode_is_run,
	input  logic [chip_io_pkg::port_width-1:0]  port_a_in,
	input  logic                                sout_low,
	input  logic                                sout_high,
	input  logic [chip_io_pkg::port_width-1:0]  core_outputs,
	output logic                                sclk_low,
	output logic                                sclk_high,
	output logic                                ssel_low,
	output logic                                ssel_high,
	output logic                                sin_low,
	output logic                                sin_high,
	output logic [chip_io_pkg::saddr_width-1:0] saddr_low,
	output logic [chip_io_pkg::saddr_width-1:0] saddr_high,
	output logic [chip_io_pkg::port_width-1:0]  port_b_out,
	output logic                                port_b_lsb_oe
);

	logic                                sclk;
	logic                                ssel;
	logic                                sin;
	logic [chip_io_pkg::saddr_width-1:0] saddr;
	logic                                sel_high;
	logic                                sout;

	// Port A layout in debug mode, bit 7 is spare
	assign sclk     = mode_is_debug & port_a_in[0];
	assign ssel     = mode_is_debug & port_a_in[1];
	assign sin      = mode_is_debug & port_a_in[2];
	assign saddr    = mode_is_debug ? port_a_in[5:3] : '0;
	assign sel_high = mode_is_debug & port_a_in[6];

	// Unselected buffer sees an idle link
	assign sclk_low   = sel_high ? 1'b0 : sclk;
	assign ssel_low   = sel_high ? 1'b0 : ssel;
	assign sin_low    = sel_high ? 1'b0 : sin;
	assign saddr_low  = sel_high ? '0 : saddr;
	assign sclk_high  = sel_high ? sclk : 1'b0;
	assign ssel_high  = sel_high ? ssel : 1'b0;
	assign sin_high   = sel_high ? sin : 1'b0;
	assign saddr_high = sel_high ? saddr : '0;

	assign sout = sel_high ? sout_high : sout_low;

	always_comb begin
		port_b_out = core_outputs;
		if (mode_is_debug) begin
			// Bits 0 to 3 are reset and division inputs here, drive them as pull-ups
			port_b_out[3:0] = 4'hf;
			port_b_out[4]   = sout;
		end
	end

	// Lower half of port B is only driven while the core runs
	assign port_b_lsb_oe = mode_is_run;

	always_comb begin
		single_sclk: assert final (!(sclk_low && sclk_high))
		else $error("both pattern buffer serial clocks active");
	end

endmodule

/* pad_ring_top.sv */
`timescale 1ns/10ps

module pad_ring_top #(
	parameter int clk_out_div_bits = 4
) (
	input  logic                                    clk_int,
	input  chip_io_pkg::mode_e                      mode,
	input  logic [chip_io_pkg::port_width-1:0]      port_a_in,
	input  logic [chip_io_pkg::port_width-1:0]      port_b_in,
	input  logic                                    pwm_low,
	input  logic                                    pwm_high,
	input  logic                                    sout_low,
	input  logic                                    sout_high,
	input  logic [chip_io_pkg::port_width-1:0]      core_outputs,
	output logic                                    reset_pat,
	output logic                                    reset_patternbuf_low,
	output logic                                    reset_patternbuf_high,
	output logic                                    pat_clock_division,
	output logic                                    clock_out,
	output logic [chip_io_pkg::imem_adr_width-1:0]  imem_write_adr,
	output logic [chip_io_pkg::imem_word_width-1:0] imem_in,
	output logic                                    imem_write,
	output logic                                    sclk_low,
	output logic                                    sclk_high,
	output logic                                    ssel_low,
	output logic                                    ssel_high,
	output logic                                    sin_low,
	output logic                                    sin_high,
	output logic [chip_io_pkg::saddr_width-1:0]     saddr_low,
	output logic [chip_io_pkg::saddr_width-1:0]     saddr_high,
	output logic [chip_io_pkg::port_width-1:0]      port_b_out,
	output logic                                    port_b_lsb_oe,
	output logic [chip_io_pkg::port_width-1:0]      port_a_sync,
	output logic                                    pwm_low_sync,
	output logic                                    pwm_high_sync
);

	localparam int pw = chip_io_pkg::port_width;
	// Port A, two load strobes and two PWM pins
	localparam int sync_width = pw + 4;

	logic [sync_width-1:0] sync_in;
	logic [sync_width-1:0] sync_out;
	logic                  mode_is_reset;
	logic                  mode_is_debug;
	logic                  mode_is_run;
	logic                  mode_is_memload;
	logic                  load_strobe_sync;
	logic                  load_write_sync;

	assign sync_in          = {pwm_high, pwm_low, port_b_in[1:0], port_a_in};
	assign port_a_sync      = sync_out[pw-1:0];
	assign load_strobe_sync = sync_out[pw];
	assign load_write_sync  = sync_out[pw+1];
	assign pwm_low_sync     = sync_out[pw+2];
	assign pwm_high_sync    = sync_out[pw+3];

	input_sync #(
		.width(sync_width)
	) u_input_sync (
		.clk_int      (clk_int),
		.mode_is_reset(mode_is_reset),
		.async_in     (sync_in),
		.sync_out     (sync_out)
	);

	chip_control #(
		.clk_out_div_bits(clk_out_div_bits)
	) u_chip_control (
		.clk_int              (clk_int),
		.mode                 (mode),
		.port_b_in            (port_b_in[2:0]),
		.division_pin         (port_b_in[3]),
		.mode_is_reset        (mode_is_reset),
		.mode_is_debug        (mode_is_debug),
		.mode_is_run          (mode_is_run),
		.mode_is_memload      (mode_is_memload),
		.reset_pat            (reset_pat),
		.reset_patternbuf_low (reset_patternbuf_low),
		.reset_patternbuf_high(reset_patternbuf_high),
		.pat_clock_division   (pat_clock_division),
		.clock_out            (clock_out)
	);

	imem_loader u_imem_loader (
		.clk_int         (clk_int),
		.mode_is_reset   (mode_is_reset),
		.mode_is_memload (mode_is_memload),
		.port_a_sync     (port_a_sync),
		.load_strobe_sync(load_strobe_sync),
		.load_write_sync (load_write_sync),
		.imem_write_adr  (imem_write_adr),
		.imem_in         (imem_in),
		.imem_write      (imem_write)
	);

	// Debug link runs straight from the pads, the serial clock is slow
	debug_port u_debug_port (
		.mode_is_debug(mode_is_debug),
		.mode_is_run  (mode_is_run),
		.port_a_in    (port_a_in),
		.sout_low     (sout_low),
		.sout_high    (sout_high),
		.core_outputs (core_outputs),
		.sclk_low     (sclk_low),
		.sclk_high    (sclk_high),
		.ssel_low     (ssel_low),
		.ssel_high    (ssel_high),
		.sin_low      (sin_low),
		.sin_high     (sin_high),
		.saddr_low    (saddr_low),
		.saddr_high   (saddr_high),
		.port_b_out   (port_b_out),
		.port_b_lsb_oe(port_b_lsb_oe)
	);

endmodule

/* tb_pad_ring.sv */
`timescale 1ns/10ps

module tb_pad_ring;

	localparam int pw = chip_io_pkg::port_width;
	localparam int reset_cycles = 8;
	localparam int run_cycles = 32;
	localparam int write_timeout = 20;

	logic                                    clk_int;
	chip_io_pkg::mode_e                      mode;
	logic [pw-1:0]                           port_a_in;
	logic [pw-1:0]                           port_b_in;
	logic                                    pwm_low;
	logic                                    pwm_high;
	logic                                    sout_low;
	logic                                    sout_high;
	logic [pw-1:0]                           core_outputs;
	logic                                    reset_pat;
	logic                                    reset_patternbuf_low;
	logic                                    reset_patternbuf_high;
	logic                                    pat_clock_division;
	logic                                    clock_out;
	logic [chip_io_pkg::imem_adr_width-1:0]  imem_write_adr;
	logic [chip_io_pkg::imem_word_width-1:0] imem_in;
	logic                                    imem_write;
	logic                                    sclk_low;
	logic                                    sclk_high;
	logic                                    ssel_low;
	logic                                    ssel_high;
	logic                                    sin_low;
	logic                                    sin_high;
	logic [chip_io_pkg::saddr_width-1:0]     saddr_low;
	logic [chip_io_pkg::saddr_width-1:0]     saddr_high;
	logic [pw-1:0]                           port_b_out;
	logic                                    port_b_lsb_oe;
	logic [pw-1:0]                           port_a_sync;
	logic                                    pwm_low_sync;
	logic                                    pwm_high_sync;
	logic [11:0]                             serial_all;
	logic [2:0]                              resets_all;
	integer                                  seed;

	// Every serial line to both pattern buffers
	assign serial_all = {sclk_low, sclk_high, ssel_low, ssel_high, sin_low, sin_high,
		saddr_low, saddr_high};
	assign resets_all = {reset_pat, reset_patternbuf_high, reset_patternbuf_low};

	pad_ring_top #(
		.clk_out_div_bits(4)
	) uut (
		.clk_int(clk_int), .mode(mode), .port_a_in(port_a_in), .port_b_in(port_b_in),
		.pwm_low(pwm_low), .pwm_high(pwm_high), .sout_low(sout_low), .sout_high(sout_high),
		.core_outputs(core_outputs), .reset_pat(reset_pat),
		.reset_patternbuf_low(reset_patternbuf_low),
		.reset_patternbuf_high(reset_patternbuf_high),
		.pat_clock_division(pat_clock_division), .clock_out(clock_out),
		.imem_write_adr(imem_write_adr), .imem_in(imem_in), .imem_write(imem_write),
		.sclk_low(sclk_low), .sclk_high(sclk_high), .ssel_low(ssel_low),
		.ssel_high(ssel_high), .sin_low(sin_low), .sin_high(sin_high),
		.saddr_low(saddr_low), .saddr_high(saddr_high), .port_b_out(port_b_out),
		.port_b_lsb_oe(port_b_lsb_oe), .port_a_sync(port_a_sync),
		.pwm_low_sync(pwm_low_sync), .pwm_high_sync(pwm_high_sync)
	);

	always #50 clk_int = ~clk_int;

	task automatic report_mismatch(input string name, input logic [63:0] exp,
		input logic [63:0] act);
		$display("FAIL %s expected 0x%0h actual 0x%0h", name, exp, act);
		$display("Regression failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_equal(input string name, input logic [63:0] exp,
		input logic [63:0] act);
		value_match: assert (act === exp) else report_mismatch(name, exp, act);
	endtask

	// Core and buffers must stay in reset for the whole memory load
	memload_holds_reset: assert property (
		@(posedge clk_int) mode == chip_io_pkg::mode_memload |-> reset_pat
	) else report_mismatch("memload_reset_pat", 64'd1, {63'd0, reset_pat});

	write_needs_memload: assert property (
		@(posedge clk_int) imem_write |-> mode == chip_io_pkg::mode_memload
	) else report_mismatch("write_outside_memload", 64'd0, {63'd0, imem_write});

	task automatic check_reset_mode();
		check_equal("reset_resets", 3'b111, resets_all);
		check_equal("reset_division", 1'b1, pat_clock_division);
		check_equal("reset_clock_out", 1'b0, clock_out);
		check_equal("reset_imem_write", 1'b0, imem_write);
		check_equal("reset_lsb_oe", 1'b0, port_b_lsb_oe);
		check_equal("reset_serial", 12'd0, serial_all);
		check_equal("reset_port_b_out", core_outputs, port_b_out);
	endtask

	// Run mode, with the clock divider and the synchronisers watched from reset exit
	task automatic check_run_and_clock();
		logic [pw-1:0] a_hist [0:run_cycles-1];
		logic [1:0]    pwm_hist [0:run_cycles-1];
		logic [pw-1:0] core;
		for (int k = 0; k < run_cycles; k++) begin
			@(posedge clk_int);
			if (k == 0) begin
				mode <= chip_io_pkg::mode_run;
			end
			a_hist[k] = $random(seed);
			pwm_hist[k] = $random(seed);
			core = $random(seed);
			port_a_in <= a_hist[k];
			// Port B must not reach the resets or the loader in run mode
			port_b_in <= $random(seed);
			pwm_low <= pwm_hist[k][0];
			pwm_high <= pwm_hist[k][1];
			core_outputs <= core;
			@(negedge clk_int);
			check_equal("run_clock_out", (k >> 3) & 1, clock_out);
			check_equal("run_lsb_oe", 1'b1, port_b_lsb_oe);
			check_equal("run_port_b_out", core, port_b_out);
			check_equal("run_serial", 12'd0, serial_all);
			check_equal("run_resets", 3'b000, resets_all);
			if (k >= 2) begin
				check_equal("run_port_a_sync", a_hist[k-2], port_a_sync);
				check_equal("run_pwm_sync", pwm_hist[k-2], {pwm_high_sync, pwm_low_sync});
			end
		end
	endtask

	// Division bit is taken on the first clock in debug mode
	task automatic enter_debug(input logic division);
		@(posedge clk_int);
		mode <= chip_io_pkg::mode_debug;
		port_b_in <= {4'h0, division, 3'b000};
		@(posedge clk_int);
		@(negedge clk_int);
		check_equal("debug_entry_division", division, pat_clock_division);
	endtask

	task automatic check_debug_routing(input logic division, input int steps);
		logic [pw-1:0] a;
		logic [pw-1:0] b;
		logic [pw-1:0] core;
		logic          so_l;
		logic          so_h;
		logic [5:0]    link;
		for (int i = 0; i < steps; i++) begin
			@(posedge clk_int);
			a = $random(seed);
			b = $random(seed);
			core = $random(seed);
			so_l = $random(seed);
			so_h = $random(seed);
			port_a_in <= a;
			port_b_in <= b;
			core_outputs <= core;
			sout_low <= so_l;
			sout_high <= so_h;
			@(negedge clk_int);
			link = {a[0], a[1], a[2], a[5:3]};
			check_equal("debug_low_link", a[6] ? 6'd0 : link,
				{sclk_low, ssel_low, sin_low, saddr_low});
			check_equal("debug_high_link", a[6] ? link : 6'd0,
				{sclk_high, ssel_high, sin_high, saddr_high});
			check_equal("debug_port_b_out", {core[7:5], a[6] ? so_h : so_l, 4'hf}, port_b_out);
			check_equal("debug_buffer_resets", b[2:0], resets_all);
			check_equal("debug_division_hold", division, pat_clock_division);
		end
	endtask

	task automatic check_memory_load();
		logic [7:0] bytes [0:chip_io_pkg::load_bytes-1];
		int         waited;
		// Let the load strobes settle at 0 before memload mode starts
		@(posedge clk_int);
		port_b_in <= '0;
		repeat (3) @(posedge clk_int);
		mode <= chip_io_pkg::mode_memload;
		for (int i = 0; i < chip_io_pkg::load_bytes; i++) begin
			bytes[i] = $random(seed);
			@(posedge clk_int);
			port_a_in <= bytes[i];
			@(posedge clk_int);
			port_b_in[0] <= 1'b1;
			repeat (3) @(posedge clk_int);
			port_b_in[0] <= 1'b0;
			repeat (3) @(posedge clk_int);
		end
		port_b_in[1] <= 1'b1;
		waited = 0;
		while (imem_write !== 1'b1 && waited < write_timeout) begin
			@(negedge clk_int);
			waited++;
		end
		if (imem_write !== 1'b1) begin
			$display("imem_write did not rise within %0d cycles of the write strobe",
				write_timeout);
			$display("Regression failed");
			$fatal(1, "write strobe timeout");
		end
		check_equal("load_write_adr", {bytes[0][1:0], bytes[1]}, imem_write_adr);
		check_equal("load_imem_in", {bytes[2][6:0], bytes[3], bytes[4],
			bytes[5][6:0], bytes[6], bytes[7]}, imem_in);
		check_equal("load_reset_pat", 1'b1, reset_pat);
		@(posedge clk_int);
		port_b_in <= '0;
		mode <= chip_io_pkg::mode_reset;
		@(negedge clk_int);
		check_equal("load_exit_write", 1'b0, imem_write);
		check_equal("load_exit_adr", 10'd0, imem_write_adr);
		check_equal("load_exit_word", 46'd0, imem_in);
	endtask

	initial begin
		seed = 42;
		clk_int = 1'b0;
		mode = chip_io_pkg::mode_reset;
		port_a_in = '0;
		port_b_in = '0;
		pwm_low = 1'b0;
		pwm_high = 1'b0;
		sout_low = 1'b0;
		sout_high = 1'b0;
		core_outputs = '0;

		// Random pins in reset mode must not reach any output
		for (int k = 0; k < reset_cycles; k++) begin
			@(posedge clk_int);
			port_a_in <= $random(seed);
			core_outputs <= $random(seed);
			sout_low <= 1'b1;
			@(negedge clk_int);
			check_reset_mode();
		end

		check_run_and_clock();
		enter_debug(1'b0);
		check_debug_routing(1'b0, 24);

		// Back through run mode, the next entry takes the pin again
		@(posedge clk_int);
		mode <= chip_io_pkg::mode_run;
		port_b_in <= '0;
		repeat (2) @(posedge clk_int);
		enter_debug(1'b1);
		check_debug_routing(1'b1, 16);

		check_memory_load();

		$display("Regression passed");
		$finish;
	end

endmodule

/* src.f */
chip_io_pkg.sv
input_sync.sv
chip_control.sv
imem_loader.sv
debug_port.sv
pad_ring_top.sv
tb_pad_ring.sv

/* Bender.yml */
package:
  name: pad_ring

sources:
  - files:
      - chip_io_pkg.sv
      - input_sync.sv
      - chip_control.sv
      - imem_loader.sv
      - debug_port.sv
      - pad_ring_top.sv
  - target: test
    files:
      - tb_pad_ring.sv
